//--- enc_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoder channel widths and limits
//   position / host data width, period width
//   input synchronizer depth
//   period stop values (motor stopped)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ENC_MACROS_SVH
`define ENC_MACROS_SVH

// position counter, also the host data width
`define ENC_POS_W        32

// period word, signed
`define ENC_PERIOD_W     16

// stop values, sized to ENC_PERIOD_W
`define ENC_PERIOD_MAX   16'sh7fff   // forward, largest positive
`define ENC_PERIOD_MIN   16'sh8000   // reverse, most negative

// flops per raw encoder line
`define ENC_SYNC_STAGES  2

`endif

//--- enc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoder channel types
//   quad_state_e  gray state of the a/b pair
//   enc_event_t   decoded count event
//   enc_cfg_t     channel control bits
//   enc_op_e      host command opcodes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package enc_pkg;

    // {a, b} as sampled, forward runs 00 -> 01 -> 11 -> 10
    typedef enum logic [1:0] {
        Q00 = 2'b00,
        Q01 = 2'b01,
        Q11 = 2'b11,
        Q10 = 2'b10
    } quad_state_e;

    typedef struct packed {
        logic tick;         // one-cycle count event
        logic dir;          // 1 = forward
        logic err;          // both lines moved at once
    } enc_event_t;

    typedef struct packed {
        logic enable;       // counting allowed
        logic invert_dir;   // swap forward sense
    } enc_cfg_t;

    typedef enum logic [2:0] {
        OP_NOP         = 3'd0,
        OP_SET_CTRL    = 3'd1,
        OP_SET_POS     = 3'd2,
        OP_READ_POS    = 3'd3,
        OP_READ_PERIOD = 3'd4,
        OP_READ_STATUS = 3'd5
    } enc_op_e;

endpackage

//--- enc_quad_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// quadrature decoder
//   two-line input synchronizer
//   gray state tracking, tick / dir / err generation
//   signed position counter with preset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "enc_macros.svh"

module enc_quad_decoder
    import enc_pkg::*;
(
    input  logic                        clk_fast,
    input  logic                        reset,
    input  logic                        enc_a,          // raw line a
    input  logic                        enc_b,          // raw line b
    input  enc_cfg_t                    cfg,
    input  logic                        pos_load,       // preset strobe
    input  logic [`ENC_POS_W-1:0]       pos_load_value,
    output enc_event_t                  evt,
    output logic signed [`ENC_POS_W-1:0] position
);

    logic [`ENC_SYNC_STAGES-1:0] sync_a;    // msb is the synced value
    logic [`ENC_SYNC_STAGES-1:0] sync_b;
    quad_state_e                 cur_state;
    quad_state_e                 prev_state; // last sampled pair
    quad_state_e                 fwd_next;   // one step forward from prev
    quad_state_e                 rev_next;   // one step back from prev
    logic                        is_fwd;
    logic                        is_rev;
    logic                        is_jump;
    enc_event_t                  evt_next;

    assign cur_state = quad_state_e'({sync_a[`ENC_SYNC_STAGES-1],
                                      sync_b[`ENC_SYNC_STAGES-1]});

    // neighbours of the previous state on the gray ring
    always_comb
    begin
        case (prev_state)
            Q00:     begin fwd_next = Q01; rev_next = Q10; end
            Q01:     begin fwd_next = Q11; rev_next = Q00; end
            Q11:     begin fwd_next = Q10; rev_next = Q01; end
            default: begin fwd_next = Q00; rev_next = Q11; end
        endcase
    end

    assign is_fwd  = (cur_state == fwd_next);
    assign is_rev  = (cur_state == rev_next);
    assign is_jump = (cur_state != prev_state) && !is_fwd && !is_rev; // 2-bit move

    always_comb
    begin
        evt_next.tick = cfg.enable && (is_fwd || is_rev);
        evt_next.dir  = (is_fwd || is_rev) ? (is_fwd ^ cfg.invert_dir) : evt.dir; // keep last
        evt_next.err  = cfg.enable && is_jump;
    end

    // 2 sync stages + 1 decode stage, event lands 3 cycles after the edge
    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            sync_a     <= '0;
            sync_b     <= '0;
            prev_state <= Q00;
            evt        <= '0;
            position   <= '0;
        end
        else
        begin
            sync_a     <= {sync_a[`ENC_SYNC_STAGES-2:0], enc_a};
            sync_b     <= {sync_b[`ENC_SYNC_STAGES-2:0], enc_b};
            prev_state <= cur_state;        // tracked even while disabled
            evt        <= evt_next;
            if (pos_load)
                position <= $signed(pos_load_value);   // preset wins over a tick
            else if (evt_next.tick)
                position <= evt_next.dir ? position + 1 : position - 1;
        end
    end

endmodule

//--- enc_period_meter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoder period meter
//   counts clk_fast cycles between ticks
//   signed result by direction, saturates when stopped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "enc_macros.svh"

module enc_period_meter
    import enc_pkg::*;
(
    input  logic                           clk_fast,
    input  logic                           reset,
    input  enc_cfg_t                       cfg,
    input  enc_event_t                     evt,
    output logic signed [`ENC_PERIOD_W-1:0] period   // cycles per tick, signed by dir
);

    logic [`ENC_PERIOD_W-1:0]        cnt;        // cycles since last tick
    logic signed [`ENC_PERIOD_W-1:0] cnt_s;
    logic                            at_limit;   // counter parked at the stop value
    logic                            last_dir;

    assign cnt_s    = cnt;
    assign at_limit = (cnt == `ENC_PERIOD_MAX);

    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            cnt      <= '0;
            period   <= '0;
            last_dir <= 1'b0;
        end
        else if (!cfg.enable)
        begin
            cnt <= '0;                      // period holds its last value
        end
        else if (evt.tick)
        begin
            // restart at 1, the tick cycle itself counts
            cnt      <= 1;
            last_dir <= evt.dir;
            if (at_limit)
                period <= evt.dir ? `ENC_PERIOD_MAX : `ENC_PERIOD_MIN;
            else
                period <= evt.dir ? cnt_s : -cnt_s;
        end
        else if (at_limit)
        begin
            // too slow, report motor stopped
            period <= last_dir ? `ENC_PERIOD_MAX : `ENC_PERIOD_MIN;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- enc_config_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoder channel register block
//   host command decode, control register
//   position preset strobe, sticky error flag
//   read-data capture with valid pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "enc_macros.svh"

module enc_config_regs
    import enc_pkg::*;
(
    input  logic                           clk_fast,
    input  logic                           reset,
    input  logic                           cmd_valid,      // one-cycle command strobe
    input  enc_op_e                        cmd_op,
    input  logic [`ENC_POS_W-1:0]          cmd_wdata,
    input  enc_event_t                     evt,
    input  logic signed [`ENC_POS_W-1:0]    position,
    input  logic signed [`ENC_PERIOD_W-1:0] period,
    output enc_cfg_t                       cfg,
    output logic                           pos_load,
    output logic [`ENC_POS_W-1:0]          pos_load_value,
    output logic [`ENC_POS_W-1:0]          rdata,
    output logic                           rdata_valid
);

    logic err_flag;     // sticky, cleared by a status read
    logic is_read;

    // preset goes straight to the counter, loads on the strobe edge
    assign pos_load       = cmd_valid && (cmd_op == OP_SET_POS);
    assign pos_load_value = cmd_wdata;

    assign is_read = cmd_valid && ((cmd_op == OP_READ_POS) ||
                                   (cmd_op == OP_READ_PERIOD) ||
                                   (cmd_op == OP_READ_STATUS));

    always_ff @(posedge clk_fast or posedge reset)
    begin
        if (reset)
        begin
            cfg         <= '0;              // counting off
            err_flag    <= 1'b0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rdata_valid <= is_read;
            if (cmd_valid && (cmd_op == OP_SET_CTRL))
                cfg <= enc_cfg_t'(cmd_wdata[1:0]);
            if (evt.err)
                err_flag <= 1'b1;           // new error beats the clear
            else if (cmd_valid && (cmd_op == OP_READ_STATUS))
                err_flag <= 1'b0;           // value already captured below
        end
    end

    // read data, held until the next read
    always_ff @(posedge clk_fast)
    begin
        if (cmd_valid)
        begin
            case (cmd_op)
                OP_READ_POS:    rdata <= position;
                OP_READ_PERIOD: rdata <= {{(`ENC_POS_W-`ENC_PERIOD_W){period[`ENC_PERIOD_W-1]}},
                                          period};
                OP_READ_STATUS: rdata <= {{(`ENC_POS_W-3){1'b0}}, cfg, err_flag};
                default:        rdata <= rdata;
            endcase
        end
    end

endmodule

//--- enc_channel_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one encoder channel
//   register block, quadrature decoder, period meter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "enc_macros.svh"

module enc_channel_top
    import enc_pkg::*;
(
    input  logic                  clk_fast,
    input  logic                  reset,
    input  logic                  enc_a,
    input  logic                  enc_b,
    input  logic                  cmd_valid,
    input  enc_op_e               cmd_op,
    input  logic [`ENC_POS_W-1:0] cmd_wdata,
    output logic [`ENC_POS_W-1:0] rdata,
    output logic                  rdata_valid
);

    enc_cfg_t                        cfg;            // to decoder and meter
    enc_event_t                      evt;            // decoder events
    logic                            pos_load;
    logic [`ENC_POS_W-1:0]           pos_load_value;
    logic signed [`ENC_POS_W-1:0]    position;
    logic signed [`ENC_PERIOD_W-1:0] period;

    // host side
    enc_config_regs u_regs (
        .clk_fast       (clk_fast),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_op         (cmd_op),
        .cmd_wdata      (cmd_wdata),
        .evt            (evt),
        .position       (position),
        .period         (period),
        .cfg            (cfg),
        .pos_load       (pos_load),
        .pos_load_value (pos_load_value),
        .rdata          (rdata),
        .rdata_valid    (rdata_valid)
    );

    enc_quad_decoder u_decoder (
        .clk_fast       (clk_fast),
        .reset          (reset),
        .enc_a          (enc_a),
        .enc_b          (enc_b),
        .cfg            (cfg),
        .pos_load       (pos_load),
        .pos_load_value (pos_load_value),
        .evt            (evt),
        .position       (position)
    );

    enc_period_meter u_meter (
        .clk_fast (clk_fast),
        .reset    (reset),
        .cfg      (cfg),
        .evt      (evt),
        .period   (period)
    );

endmodule

//--- tb_enc_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoder channel testbench
//   table of test entries applied in a loop
//   quadrature line generator, host command driver
//   typed compare tasks, cycle-count timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "enc_macros.svh"

module tb_enc_channel
    import enc_pkg::*;
();

    localparam logic [1:0] MOVE_REV  = 2'd0;
    localparam logic [1:0] MOVE_FWD  = 2'd1;
    localparam logic [1:0] MOVE_JUMP = 2'd2;   // both lines at once
    localparam int NUM_TESTS     = 9;
    localparam int SETTLE_CYCLES = 6;          // edge to readable is 4
    localparam int STOP_EXTRA    = 40000;
    localparam int MARGIN        = 5000;

    typedef struct packed {
        enc_cfg_t                         ctrl;
        logic                             load;       // issue a preset first
        logic [1:0]                       move;
        logic [15:0]                      steps;
        logic [15:0]                      spacing;    // cycles between edges
        logic signed [`ENC_POS_W-1:0]     preset;
        logic signed [`ENC_POS_W-1:0]     exp_pos;
        logic signed [`ENC_PERIOD_W-1:0]  exp_period;
        logic                             exp_err;
    } test_entry_t;

    logic                  clk_fast;
    logic                  reset;
    logic                  enc_a;
    logic                  enc_b;
    logic                  cmd_valid;
    enc_op_e               cmd_op;
    logic [`ENC_POS_W-1:0] cmd_wdata;
    logic [`ENC_POS_W-1:0] rdata;
    logic                  rdata_valid;

    test_entry_t tests [NUM_TESTS];
    string       names [NUM_TESTS];
    int          n_tests = 0;
    int          pos_errors = 0;
    int          period_errors = 0;
    int          status_errors = 0;
    int          protocol_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;      // 0 until the table is built
    logic [31:0] rng_state = 32'hf60c;

    enc_channel_top UUT (
        .clk_fast    (clk_fast),
        .reset       (reset),
        .enc_a       (enc_a),
        .enc_b       (enc_b),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_wdata   (cmd_wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    always #50 clk_fast = ~clk_fast;   // 100 ns period

    // watchdog
    always @(posedge clk_fast)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout, run still busy after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // {a, b} ring with forward as 00 01 11 10
    function automatic logic [1:0] next_lines(input logic [1:0] ab, input logic [1:0] move);
        case (move)
            MOVE_FWD:  return (ab == 2'b00) ? 2'b01 : (ab == 2'b01) ? 2'b11 :
                              (ab == 2'b11) ? 2'b10 : 2'b00;
            MOVE_REV:  return (ab == 2'b00) ? 2'b10 : (ab == 2'b10) ? 2'b11 :
                              (ab == 2'b11) ? 2'b01 : 2'b00;
            default:   return ~ab;       // illegal double change
        endcase
    endfunction

    task add_test(input string name, input enc_cfg_t ctrl, input logic load,
                  input logic [1:0] move, input int steps, input int spacing,
                  input int preset, input int exp_pos, input int exp_period,
                  input logic exp_err);
        names[n_tests]            = name;
        tests[n_tests].ctrl       = ctrl;
        tests[n_tests].load       = load;
        tests[n_tests].move       = move;
        tests[n_tests].steps      = steps;
        tests[n_tests].spacing    = spacing;
        tests[n_tests].preset     = preset;
        tests[n_tests].exp_pos    = exp_pos;
        tests[n_tests].exp_period = exp_period;
        tests[n_tests].exp_err    = exp_err;
        n_tests = n_tests + 1;
    endtask

    task check_pos(input string name, input logic signed [`ENC_POS_W-1:0] exp,
                   input logic signed [`ENC_POS_W-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s position expected %0d actual %0d", name, exp, act);
            pos_errors = pos_errors + 1;
        end
    endtask

    task check_period(input string name, input logic signed [`ENC_PERIOD_W-1:0] exp,
                      input logic signed [`ENC_PERIOD_W-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s period expected %0d actual %0d", name, exp, act);
            period_errors = period_errors + 1;
        end
    endtask

    task check_status(input string name, input logic exp_err, input enc_cfg_t exp_cfg,
                      input logic act_err, input enc_cfg_t act_cfg);
        if (act_err !== exp_err || act_cfg !== exp_cfg)
        begin
            $display("ERROR %s status expected err %b cfg %b actual err %b cfg %b",
                     name, exp_err, exp_cfg, act_err, act_cfg);
            status_errors = status_errors + 1;
        end
    endtask

    // one-cycle strobe from falling edge to falling edge
    task send_cmd(input enc_op_e op, input logic [`ENC_POS_W-1:0] wdata);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_wdata = wdata;
        @(negedge clk_fast);
        cmd_valid = 1'b0;
        cmd_op    = OP_NOP;
        cmd_wdata = '0;
    endtask

    // valid must be up one cycle after the strobe
    task take_read(input string name, output logic [`ENC_POS_W-1:0] data);
        if (rdata_valid !== 1'b1)
        begin
            $display("read for %s got no rdata_valid one cycle after the strobe", name);
            protocol_errors = protocol_errors + 1;
        end
        data = rdata;
    endtask

    // three reads back to back before the compares
    task verify_state(input string name, input logic signed [`ENC_POS_W-1:0] exp_pos,
                      input logic signed [`ENC_PERIOD_W-1:0] exp_period,
                      input logic exp_err, input enc_cfg_t exp_cfg);
        logic [`ENC_POS_W-1:0] pos_w;
        logic [`ENC_POS_W-1:0] per_w;
        logic [`ENC_POS_W-1:0] stat_w;
        logic [`ENC_POS_W-`ENC_PERIOD_W-1:0] exp_fill;   // sign bits above the period
        exp_fill = {(`ENC_POS_W-`ENC_PERIOD_W){exp_period[`ENC_PERIOD_W-1]}};
        send_cmd(OP_READ_POS, '0);
        take_read(name, pos_w);
        send_cmd(OP_READ_PERIOD, '0);
        take_read(name, per_w);
        send_cmd(OP_READ_STATUS, '0);
        take_read(name, stat_w);
        @(negedge clk_fast);
        if (rdata_valid !== 1'b0)
        begin
            $display("rdata_valid for %s stayed high with no read pending", name);
            protocol_errors = protocol_errors + 1;
        end
        check_pos(name, exp_pos, pos_w);
        check_period(name, exp_period, per_w[`ENC_PERIOD_W-1:0]);
        if (per_w[`ENC_POS_W-1:`ENC_PERIOD_W] !== exp_fill)
        begin
            $display("ERROR %s period sign bits expected %h actual %h",
                     name, exp_fill, per_w[`ENC_POS_W-1:`ENC_PERIOD_W]);
            period_errors = period_errors + 1;
        end
        check_status(name, exp_err, exp_cfg, stat_w[0], enc_cfg_t'(stat_w[2:1]));
    endtask

    initial
    begin
        logic [`ENC_POS_W-1:0] clr_w;
        int idle;
        clk_fast  = 1'b0;
        reset     = 1'b1;
        enc_a     = 1'b0;
        enc_b     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_NOP;
        cmd_wdata = '0;

        // name, ctrl {enable, invert}, load, move, steps, spacing, preset,
        // then expected position, period, error
        add_test("fwd_count",    2'b10, 1'b1, MOVE_FWD,  10,    20,  100,  110,     20, 1'b0);
        add_test("rev_count",    2'b10, 1'b0, MOVE_REV,   4,    12,    0,  106,    -12, 1'b0);
        add_test("period_slow",  2'b10, 1'b1, MOVE_FWD,   5,   250,    0,    5,    250, 1'b0);
        add_test("invert_fwd",   2'b11, 1'b1, MOVE_FWD,   6,    30, 1000,  994,    -30, 1'b0);
        add_test("invert_rev",   2'b11, 1'b0, MOVE_REV,   3,    40,    0,  997,     40, 1'b0);
        add_test("illegal_jump", 2'b10, 1'b0, MOVE_JUMP,  1,    10,    0,  997,     40, 1'b1);
        add_test("disabled",     2'b01, 1'b0, MOVE_FWD,   4,    15,    0,  997,     40, 1'b0);
        add_test("stop_fwd",     2'b10, 1'b0, MOVE_FWD,   1, 33000,    0,  998,  32767, 1'b0);
        add_test("stop_rev",     2'b10, 1'b0, MOVE_REV,   1, 33000,    0,  997, -32768, 1'b0);

        for (int i = 0; i < n_tests; i++)
            cycle_limit = cycle_limit + tests[i].steps * tests[i].spacing;
        cycle_limit = cycle_limit + STOP_EXTRA + MARGIN;

        repeat (4) @(posedge clk_fast);
        @(negedge clk_fast);
        reset = 1'b0;
        @(negedge clk_fast);
        verify_state("reset_state", 0, 0, 1'b0, 2'b00);

        for (int i = 0; i < n_tests; i++)
        begin
            rng_state = xorshift32(rng_state);
            idle = rng_state[2:0];              // jitter only before the entry
            repeat (idle) @(negedge clk_fast);
            send_cmd(OP_SET_CTRL, {30'd0, tests[i].ctrl});
            if (tests[i].load)
                send_cmd(OP_SET_POS, tests[i].preset);
            for (int s = 0; s < tests[i].steps; s++)
            begin
                {enc_a, enc_b} = next_lines({enc_a, enc_b}, tests[i].move);
                repeat (tests[i].spacing) @(negedge clk_fast);
            end
            repeat (SETTLE_CYCLES) @(negedge clk_fast);
            verify_state(names[i], tests[i].exp_pos, tests[i].exp_period,
                         tests[i].exp_err, tests[i].ctrl);
            if (tests[i].exp_err)
            begin
                // previous status read clears the sticky flag
                send_cmd(OP_READ_STATUS, '0);
                take_read(names[i], clr_w);
                check_status({names[i], "_clear"}, 1'b0, tests[i].ctrl,
                             clr_w[0], enc_cfg_t'(clr_w[2:1]));
            end
        end

        $display("errors: position %0d period %0d status %0d protocol %0d",
                 pos_errors, period_errors, status_errors, protocol_errors);
        if (pos_errors + period_errors + status_errors + protocol_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
enc_pkg.sv
enc_quad_decoder.sv
enc_period_meter.sv
enc_config_regs.sv
enc_channel_top.sv
tb_enc_channel.sv
